//--- verilog.f
+incdir+.
mchan_pkg.sv
mchan_fifo.sv
trans_id_alloc.sv
ctrl_fsm.sv
mchan_ctrl_top.sv
tb_mchan_ctrl.sv

//--- Bender.yml
package:
  name: mchan_ctrl

export_include_dirs:
  - .

sources:
  - files:
      - mchan_pkg.sv
      - mchan_fifo.sv
      - trans_id_alloc.sv
      - ctrl_fsm.sv
      - mchan_ctrl_top.sv
  - target: test
    files:
      - tb_mchan_ctrl.sv

//--- tb_mchan_ctrl.sv
// ******************************
// DMA control front end testbench
// Table of port accesses, queue pops and checks
// ******************************

`include "mchan_cfg.svh"

module tb_mchan_ctrl
   import mchan_pkg::*;
();

   localparam int          DRV_DLY     = 2;
   localparam int          GNT_TIMEOUT = 8;
   localparam int          RSP_TIMEOUT = 4;
   localparam logic [31:0] CMD_ADDR    = 32'h1020_0000 | `MCHAN_CMD_ADDR;
   localparam logic [31:0] STATUS_ADDR = 32'h1020_0000 | `MCHAN_STATUS_ADDR;
   localparam logic [31:0] Q_CMD       = 32'd0;   // Queue selectors for pop and check rows
   localparam logic [31:0] Q_TCDM      = 32'd1;
   localparam logic [31:0] Q_EXT       = 32'd2;

   typedef enum { OP_READ, OP_WRITE, OP_DONE, OP_POP, OP_CHECK, OP_IDLE } op_kind_t;

   typedef struct {
      op_kind_t    kind;
      logic [31:0] addr;  // Port address or queue selector
      logic [31:0] data;
      logic        ok;    // Grant expected, or entry expected
      logic [31:0] exp;
   } op_t;

   logic        clk_i;
   logic        rst_ni;
   logic        ctrl_req_valid_i;
   ctrl_req_t   ctrl_req_i;
   logic        ctrl_gnt_o;
   ctrl_rsp_t   ctrl_rsp_o;
   cmd_t        cmd_o;
   logic        cmd_valid_o;
   logic        cmd_pop_i;
   tcdm_add_t   tcdm_add_o;
   logic        tcdm_valid_o;
   logic        tcdm_pop_i;
   ext_add_t    ext_add_o;
   logic        ext_valid_o;
   logic        ext_pop_i;
   logic        trans_done_i;
   sid_t        trans_done_sid_i;
   logic        busy_o;
   op_t         ops[$];
   logic [31:0] rng_state = 32'h5589;

   mchan_ctrl_top mchan_ctrl_top_inst (.*);

   initial
   begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   function logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // Length is bytes minus one, flags from bit 19 upward
   function automatic logic [31:0] expect_cmd(input logic [31:0] d, input int sid);
      logic [`MCHAN_LEN_WIDTH-1:0] len;
      len = d[`MCHAN_LEN_WIDTH-1:0] - 1'b1;
      return {6'b0, len, d[19], d[20], d[21], d[22], d[23], 2'(sid)};
   endfunction

   task end_with_failure(input string reason);
      if (reason != "")
         $display("%s", reason);
      $display("TEST RESULT: FAIL");
      $fatal(1);
   endtask

   task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("ERROR: %s = 0x%08h, expected 0x%08h", name, got, exp);
         end_with_failure("");
      end
   endtask

   // ******************************
   // Table construction
   // ******************************
   task add_op(input op_kind_t kind, input logic [31:0] addr, input logic [31:0] data,
               input logic ok, input logic [31:0] exp);
      op_t op;
      op.kind = kind;
      op.addr = addr;
      op.data = data;
      op.ok   = ok;
      op.exp  = exp;
      ops.push_back(op);
   endtask

   task add_heads(input logic [31:0] c, input int sid, input logic [31:0] t,
                  input logic [31:0] e);
      add_op(OP_CHECK, Q_CMD, 0, 1'b1, expect_cmd(c, sid));
      add_op(OP_CHECK, Q_TCDM, 0, 1'b1, t & 32'h0000_0FFF);  // Low 12 bits
      add_op(OP_CHECK, Q_EXT, 0, 1'b1, e & 32'h1FFF_FFFF);   // Low 29 bits
   endtask

   task add_pops();
      add_op(OP_POP, Q_CMD, 0, 1'b1, 0);
      add_op(OP_POP, Q_TCDM, 0, 1'b1, 0);
      add_op(OP_POP, Q_EXT, 0, 1'b1, 0);
   endtask

   task build_table();
      logic [31:0] c [4];
      logic [31:0] t [4];
      logic [31:0] e [4];
      for (int s = 0; s < 4; s++)
      begin
         c[s] = next_rand();
         t[s] = next_rand();
         e[s] = next_rand();
         add_op(OP_READ, CMD_ADDR, 0, 1'b1, s);  // IDs handed out lowest first
         add_op(OP_WRITE, CMD_ADDR, c[s], 1'b1, 0);
         add_op(OP_WRITE, CMD_ADDR, t[s], 1'b1, 0);
         add_op(OP_WRITE, CMD_ADDR, e[s], 1'b1, 0);
         add_heads(c[s], s, t[s], e[s]);
         add_pops();
      end
      add_op(OP_CHECK, Q_CMD, 0, 1'b0, 0);
      add_op(OP_READ, CMD_ADDR, 0, 1'b0, 0);  // No ID left
      add_op(OP_READ, STATUS_ADDR, 0, 1'b1, 32'h000F_0000);
      // Completion and status
      add_op(OP_DONE, 0, 2, 1'b1, 0);
      add_op(OP_DONE, 0, 0, 1'b1, 0);
      add_op(OP_READ, STATUS_ADDR, 0, 1'b1, 32'h000F_0005);
      add_op(OP_WRITE, STATUS_ADDR, 32'h5, 1'b1, 0);
      add_op(OP_READ, STATUS_ADDR, 0, 1'b1, 32'h000A_0000);
      // Fill the command queue, then push against it
      for (int s = 0; s < 3; s++)
      begin
         c[s] = next_rand();
         t[s] = next_rand();
         e[s] = next_rand();
      end
      add_op(OP_READ, CMD_ADDR, 0, 1'b1, 0);
      add_op(OP_WRITE, CMD_ADDR, c[0], 1'b1, 0);
      add_op(OP_WRITE, CMD_ADDR, t[0], 1'b1, 0);
      add_op(OP_WRITE, CMD_ADDR, e[0], 1'b1, 0);
      add_op(OP_READ, CMD_ADDR, 0, 1'b1, 2);
      add_op(OP_WRITE, CMD_ADDR, c[1], 1'b1, 0);
      add_op(OP_WRITE, CMD_ADDR, t[1], 1'b1, 0);
      add_op(OP_WRITE, CMD_ADDR, e[1], 1'b1, 0);
      add_op(OP_WRITE, STATUS_ADDR, 32'h2, 1'b1, 0);
      add_op(OP_READ, CMD_ADDR, 0, 1'b1, 1);
      add_op(OP_WRITE, CMD_ADDR, c[2], 1'b0, 0);  // Queue full
      add_heads(c[0], 0, t[0], e[0]);
      add_op(OP_POP, Q_CMD, 0, 1'b1, 0);
      add_op(OP_WRITE, CMD_ADDR, c[2], 1'b1, 0);
      add_op(OP_POP, Q_TCDM, 0, 1'b1, 0);
      add_op(OP_POP, Q_EXT, 0, 1'b1, 0);
      add_op(OP_WRITE, CMD_ADDR, t[2], 1'b1, 0);
      add_op(OP_WRITE, CMD_ADDR, e[2], 1'b1, 0);
      add_heads(c[1], 2, t[1], e[1]);
      add_pops();
      add_heads(c[2], 1, t[2], e[2]);
      add_pops();
      // Abort in place of the TCDM write
      c[3] = next_rand();
      add_op(OP_WRITE, STATUS_ADDR, 32'hF, 1'b1, 0);
      add_op(OP_READ, CMD_ADDR, 0, 1'b1, 0);
      add_op(OP_WRITE, CMD_ADDR, c[3], 1'b1, 0);
      add_op(OP_READ, CMD_ADDR, 0, 1'b0, 0);
      add_op(OP_IDLE, 0, 0, 1'b1, 0);
      add_op(OP_CHECK, Q_TCDM, 0, 1'b0, 0);
      add_op(OP_CHECK, Q_CMD, 0, 1'b1, expect_cmd(c[3], 0));
      add_op(OP_POP, Q_CMD, 0, 1'b1, 0);
      add_op(OP_READ, STATUS_ADDR, 0, 1'b1, 32'h0001_0000);  // Aborted ID stays taken
   endtask

   // ******************************
   // Row execution
   // ******************************
   task run_access(input op_t op, input int idx);
      logic        granted;
      logic        seen;
      int          cycles;
      int          waited;
      logic [31:0] rsp_data;
      pe_id_t      rsp_id;
      ctrl_req_i.typ   = (op.kind == OP_READ);
      ctrl_req_i.be    = 4'hF;
      ctrl_req_i.add   = op.addr;
      ctrl_req_i.data  = op.data;
      ctrl_req_i.id    = pe_id_t'(idx);
      ctrl_req_valid_i = 1'b1;
      granted = 1'b0;
      cycles  = 0;
      while (!granted && cycles < GNT_TIMEOUT)
      begin
         @(negedge clk_i);
         granted = ctrl_gnt_o;
         @(posedge clk_i);
         #DRV_DLY;
         cycles++;
      end
      ctrl_req_valid_i = 1'b0;  // Withdrawn when not granted
      if (!op.ok)
         check_value("ctrl_gnt_o", granted, 0);
      else if (!granted)
         end_with_failure($sformatf("Timed out waiting for the grant of row %0d", idx));
      else
      begin
         seen   = 1'b0;
         waited = 0;
         while (!seen && waited < RSP_TIMEOUT)
         begin
            @(negedge clk_i);
            waited++;
            if (ctrl_rsp_o.r_valid)
            begin
               seen     = 1'b1;
               rsp_data = ctrl_rsp_o.r_data;
               rsp_id   = ctrl_rsp_o.r_id;
            end
            @(posedge clk_i);
            #DRV_DLY;
         end
         if (!seen)
            end_with_failure($sformatf("Timed out waiting for the response of row %0d", idx));
         check_value("r_valid latency", waited, 1);
         check_value("ctrl_rsp_o.r_id", rsp_id, pe_id_t'(idx));
         if (op.kind == OP_READ)
            check_value("ctrl_rsp_o.r_data", rsp_data, op.exp);
      end
   endtask

   task run_strobe(input op_t op);
      if (op.kind == OP_DONE)
      begin
         trans_done_i     = 1'b1;
         trans_done_sid_i = sid_t'(op.data);
      end
      else
      begin
         cmd_pop_i  = (op.addr == Q_CMD);
         tcdm_pop_i = (op.addr == Q_TCDM);
         ext_pop_i  = (op.addr == Q_EXT);
      end
      @(posedge clk_i);
      #DRV_DLY;
      trans_done_i = 1'b0;
      cmd_pop_i    = 1'b0;
      tcdm_pop_i   = 1'b0;
      ext_pop_i    = 1'b0;
   endtask

   task check_queue(input op_t op);
      @(negedge clk_i);
      case (op.addr)
         Q_CMD:
         begin
            check_value("cmd_valid_o", cmd_valid_o, op.ok);
            if (op.ok)
               check_value("cmd_o", cmd_o, op.exp);
         end
         Q_TCDM:
         begin
            check_value("tcdm_valid_o", tcdm_valid_o, op.ok);
            if (op.ok)
               check_value("tcdm_add_o", tcdm_add_o, op.exp);
         end
         default:
         begin
            check_value("ext_valid_o", ext_valid_o, op.ok);
            if (op.ok)
               check_value("ext_add_o", ext_add_o, op.exp);
         end
      endcase
      @(posedge clk_i);
      #DRV_DLY;
   endtask

   initial
   begin
      rst_ni           = 1'b0;
      ctrl_req_valid_i = 1'b0;
      ctrl_req_i       = '0;
      cmd_pop_i        = 1'b0;
      tcdm_pop_i       = 1'b0;
      ext_pop_i        = 1'b0;
      trans_done_i     = 1'b0;
      trans_done_sid_i = '0;
      repeat (3) @(posedge clk_i);
      #DRV_DLY;
      rst_ni = 1'b1;
      @(negedge clk_i);
      check_value("ctrl_gnt_o", ctrl_gnt_o, 0);
      check_value("ctrl_rsp_o.r_valid", ctrl_rsp_o.r_valid, 0);
      check_value("busy_o", busy_o, 0);
      check_value("cmd_valid_o", cmd_valid_o, 0);
      check_value("tcdm_valid_o", tcdm_valid_o, 0);
      check_value("ext_valid_o", ext_valid_o, 0);
      @(posedge clk_i);
      #DRV_DLY;
      build_table();
      foreach (ops[i])
      begin
         case (ops[i].kind)
            OP_READ, OP_WRITE: run_access(ops[i], i);
            OP_DONE, OP_POP:   run_strobe(ops[i]);
            OP_CHECK:          check_queue(ops[i]);
            default:
            begin
               @(negedge clk_i);
               check_value("busy_o", busy_o, 0);  // FSM back in IDLE
               @(posedge clk_i);
               #DRV_DLY;
            end
         endcase
      end
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

//--- mchan_ctrl_top.sv
// ******************************
// DMA control front end top
// FSM, ID allocator and the three transfer queues
// ******************************

`include "mchan_cfg.svh"

module mchan_ctrl_top
   import mchan_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_ni,
   input  logic      ctrl_req_valid_i,
   input  ctrl_req_t ctrl_req_i,
   output logic      ctrl_gnt_o,
   output ctrl_rsp_t ctrl_rsp_o,
   output cmd_t      cmd_o,
   output logic      cmd_valid_o,
   input  logic      cmd_pop_i,
   output tcdm_add_t tcdm_add_o,
   output logic      tcdm_valid_o,
   input  logic      tcdm_pop_i,
   output ext_add_t  ext_add_o,
   output logic      ext_valid_o,
   input  logic      ext_pop_i,
   input  logic      trans_done_i,
   input  sid_t      trans_done_sid_i,
   output logic      busy_o
);

   logic        alloc_req;
   logic        alloc_gnt;
   sid_t        alloc_sid;
   trans_mask_t clr;
   trans_mask_t alloc_status;
   trans_mask_t done_status;
   logic        cmd_push;
   logic        cmd_full;
   cmd_t        cmd_in;       // FSM side of the queues
   logic        tcdm_push;
   logic        tcdm_full;
   tcdm_add_t   tcdm_in;
   logic        ext_push;
   logic        ext_full;
   ext_add_t    ext_in;

   ctrl_fsm ctrl_fsm_inst (
      .clk_i            (clk_i),
      .rst_ni           (rst_ni),
      .ctrl_req_valid_i (ctrl_req_valid_i),
      .ctrl_req_i       (ctrl_req_i),
      .ctrl_gnt_o       (ctrl_gnt_o),
      .ctrl_rsp_o       (ctrl_rsp_o),
      .alloc_req_o      (alloc_req),
      .alloc_gnt_i      (alloc_gnt),
      .alloc_sid_i      (alloc_sid),
      .clr_o            (clr),
      .alloc_status_i   (alloc_status),
      .done_status_i    (done_status),
      .cmd_push_o       (cmd_push),
      .cmd_full_i       (cmd_full),
      .cmd_o            (cmd_in),
      .tcdm_push_o      (tcdm_push),
      .tcdm_full_i      (tcdm_full),
      .tcdm_add_o       (tcdm_in),
      .ext_push_o       (ext_push),
      .ext_full_i       (ext_full),
      .ext_add_o        (ext_in),
      .busy_o           (busy_o)
   );

   trans_id_alloc trans_id_alloc_inst (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .alloc_req_i    (alloc_req),
      .alloc_gnt_o    (alloc_gnt),
      .alloc_sid_o    (alloc_sid),
      .clr_i          (clr),
      .done_i         (trans_done_i),
      .done_sid_i     (trans_done_sid_i),
      .alloc_status_o (alloc_status),
      .done_status_o  (done_status)
   );

   // ******************************
   // Transfer queues
   // ******************************
   mchan_fifo #(.T(cmd_t), .DEPTH(`MCHAN_QUEUE_DEPTH)) cmd_fifo_inst (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .push_i  (cmd_push),
      .data_i  (cmd_in),
      .full_o  (cmd_full),
      .pop_i   (cmd_pop_i),
      .data_o  (cmd_o),
      .valid_o (cmd_valid_o)
   );

   mchan_fifo #(.T(tcdm_add_t), .DEPTH(`MCHAN_QUEUE_DEPTH)) tcdm_fifo_inst (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .push_i  (tcdm_push),
      .data_i  (tcdm_in),
      .full_o  (tcdm_full),
      .pop_i   (tcdm_pop_i),
      .data_o  (tcdm_add_o),
      .valid_o (tcdm_valid_o)
   );

   mchan_fifo #(.T(ext_add_t), .DEPTH(`MCHAN_QUEUE_DEPTH)) ext_fifo_inst (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .push_i  (ext_push),
      .data_i  (ext_in),
      .full_o  (ext_full),
      .pop_i   (ext_pop_i),
      .data_o  (ext_add_o),
      .valid_o (ext_valid_o)
   );

endmodule

//--- ctrl_fsm.sv
// ******************************
// Control port FSM
// Decodes SID, status and command accesses, feeds the queues
// ******************************

`include "mchan_cfg.svh"

module ctrl_fsm
   import mchan_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_ni,
   input  logic        ctrl_req_valid_i,
   input  ctrl_req_t   ctrl_req_i,
   output logic        ctrl_gnt_o,
   output ctrl_rsp_t   ctrl_rsp_o,
   output logic        alloc_req_o,
   input  logic        alloc_gnt_i,
   input  sid_t        alloc_sid_i,
   output trans_mask_t clr_o,
   input  trans_mask_t alloc_status_i,
   input  trans_mask_t done_status_i,
   output logic        cmd_push_o,
   input  logic        cmd_full_i,
   output cmd_t        cmd_o,
   output logic        tcdm_push_o,
   input  logic        tcdm_full_i,
   output tcdm_add_t   tcdm_add_o,
   output logic        ext_push_o,
   input  logic        ext_full_i,
   output ext_add_t    ext_add_o,
   output logic        busy_o
);

   localparam int unsigned NB = `MCHAN_NB_TRANSFERS;

   typedef enum logic [2:0] {
      IDLE, SID_RSP, STATUS_RSP, CLR_RSP, CMD, TCDM, EXT, EXT_RSP
   } state_t;

   state_t      state_q;
   state_t      state_d;
   logic        abort_q;      // Aborted request still on the port
   logic        abort_d;
   logic        wr_ok;
   logic        bad_acc;
   logic        rsp_valid_q;
   logic [31:0] rsp_data_d;
   logic [31:0] rsp_data_q;   // Latched response word
   pe_id_t      rsp_id_q;
   sid_t        sid_q;
   logic [31:0] status_word;

   assign wr_ok   = ctrl_req_valid_i && !ctrl_req_i.typ &&
                    (ctrl_req_i.add[3:0] == `MCHAN_CMD_ADDR);
   assign bad_acc = ctrl_req_valid_i && !wr_ok;  // Read or wrong address mid-sequence

   always_comb
   begin
      status_word                           = '0;
      status_word[NB-1:0]                   = done_status_i;
      status_word[`MCHAN_ALLOC_SHIFT +: NB] = alloc_status_i;
   end

   // ******************************
   // Next state and strobes
   // ******************************
   always_comb
   begin
      state_d     = state_q;
      abort_d     = abort_q && ctrl_req_valid_i;  // Released once withdrawn
      ctrl_gnt_o  = 1'b0;
      alloc_req_o = 1'b0;
      clr_o       = '0;
      cmd_push_o  = 1'b0;
      tcdm_push_o = 1'b0;
      ext_push_o  = 1'b0;
      rsp_data_d  = '0;
      case (state_q)
         IDLE:
         begin
            if (ctrl_req_valid_i && !abort_q)
            begin
               if (ctrl_req_i.add[3:0] == `MCHAN_STATUS_ADDR)
               begin
                  ctrl_gnt_o = 1'b1;  // Status always granted
                  if (ctrl_req_i.typ)
                  begin
                     rsp_data_d = status_word;
                     state_d    = STATUS_RSP;
                  end
                  else
                  begin
                     clr_o   = ctrl_req_i.data[NB-1:0];
                     state_d = CLR_RSP;
                  end
               end
               else if (ctrl_req_i.add[3:0] == `MCHAN_CMD_ADDR && ctrl_req_i.typ)
               begin
                  alloc_req_o = 1'b1;
                  if (alloc_gnt_i)  // Stalls while every ID is taken
                  begin
                     ctrl_gnt_o = 1'b1;
                     rsp_data_d = 32'(alloc_sid_i);
                     state_d    = SID_RSP;
                  end
               end
            end
         end
         STATUS_RSP, CLR_RSP, EXT_RSP:
         begin
            state_d = IDLE;
         end
         SID_RSP, CMD:
         begin
            state_d = CMD;
            if (bad_acc)
            begin
               abort_d = 1'b1;
               state_d = IDLE;
            end
            else if (wr_ok && !cmd_full_i)
            begin
               ctrl_gnt_o = 1'b1;
               cmd_push_o = 1'b1;
               state_d    = TCDM;
            end
         end
         TCDM:
         begin
            if (bad_acc)
            begin
               abort_d = 1'b1;
               state_d = IDLE;
            end
            else if (wr_ok && !tcdm_full_i)
            begin
               ctrl_gnt_o  = 1'b1;
               tcdm_push_o = 1'b1;
               state_d     = EXT;
            end
         end
         EXT:
         begin
            if (bad_acc)
            begin
               abort_d = 1'b1;
               state_d = IDLE;
            end
            else if (wr_ok && !ext_full_i)
            begin
               ctrl_gnt_o = 1'b1;
               ext_push_o = 1'b1;
               state_d    = EXT_RSP;
            end
         end
         default:
         begin
            state_d = IDLE;
         end
      endcase
   end

   // ******************************
   // Registers
   // ******************************
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         state_q     <= IDLE;
         abort_q     <= 1'b0;
         rsp_valid_q <= 1'b0;
      end
      else
      begin
         state_q     <= state_d;
         abort_q     <= abort_d;
         rsp_valid_q <= ctrl_gnt_o;  // Response one cycle after grant
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (ctrl_gnt_o)
      begin
         rsp_data_q <= rsp_data_d;
         rsp_id_q   <= ctrl_req_i.id;
      end
      if (alloc_req_o && alloc_gnt_i)
         sid_q <= alloc_sid_i;  // SID of the transfer being programmed
   end

   assign ctrl_rsp_o.r_valid = rsp_valid_q;
   assign ctrl_rsp_o.r_data  = rsp_data_q;
   assign ctrl_rsp_o.r_id    = rsp_id_q;

   // Queue payloads straight from the write data
   assign cmd_o.len  = ctrl_req_i.data[`MCHAN_LEN_WIDTH-1:0] - 1'b1;
   assign cmd_o.opc  = ctrl_req_i.data[`MCHAN_LEN_WIDTH];
   assign cmd_o.inc  = ctrl_req_i.data[`MCHAN_LEN_WIDTH + 1];
   assign cmd_o.ele  = ctrl_req_i.data[`MCHAN_LEN_WIDTH + 2];
   assign cmd_o.ile  = ctrl_req_i.data[`MCHAN_LEN_WIDTH + 3];
   assign cmd_o.ble  = ctrl_req_i.data[`MCHAN_LEN_WIDTH + 4];
   assign cmd_o.sid  = sid_q;
   assign tcdm_add_o = ctrl_req_i.data[`MCHAN_TCDM_ADD_WIDTH-1:0];
   assign ext_add_o  = ctrl_req_i.data[`MCHAN_EXT_ADD_WIDTH-1:0];

   assign busy_o = (state_q != IDLE) || ctrl_req_valid_i;

   // A queued command still owns its transfer ID
   assert property (@(posedge clk_i) disable iff (!rst_ni)
      cmd_push_o |-> alloc_status_i[sid_q]);

endmodule

//--- trans_id_alloc.sv
// ******************************
// Transfer ID allocator
// Hands out the lowest free ID, tracks allocated and done bits
// ******************************

module trans_id_alloc
   import mchan_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_ni,
   input  logic        alloc_req_i,
   output logic        alloc_gnt_o,
   output sid_t        alloc_sid_o,
   input  trans_mask_t clr_i,
   input  logic        done_i,
   input  sid_t        done_sid_i,
   output trans_mask_t alloc_status_o,
   output trans_mask_t done_status_o
);

   localparam int unsigned NB = $bits(trans_mask_t);

   trans_mask_t alloc_q;
   trans_mask_t done_q;
   trans_mask_t set_alloc;
   trans_mask_t set_done;

   // Lowest free ID wins, scanned from the top down
   always_comb
   begin
      alloc_gnt_o = 1'b0;
      alloc_sid_o = '0;
      for (int i = NB - 1; i >= 0; i--)
      begin
         if (!alloc_q[i])
         begin
            alloc_gnt_o = 1'b1;
            alloc_sid_o = sid_t'(i);
         end
      end
   end

   assign set_alloc = (alloc_req_i && alloc_gnt_o) ? trans_mask_t'(1) << alloc_sid_o : '0;
   assign set_done  = done_i ? trans_mask_t'(1) << done_sid_i : '0;

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         alloc_q <= '0;
         done_q  <= '0;
      end
      else
      begin
         alloc_q <= (alloc_q & ~clr_i) | set_alloc;  // Clear frees the ID
         done_q  <= (done_q & ~clr_i) | set_done;
      end
   end

   assign alloc_status_o = alloc_q;
   assign done_status_o  = done_q;

   // Engine only completes transfers that were handed out
   assert property (@(posedge clk_i) disable iff (!rst_ni) done_i |-> alloc_q[done_sid_i]);

endmodule

//--- mchan_fifo.sv
// ******************************
// Synchronous FIFO with a generic payload
// Full and not-empty flags, push and pop in one cycle
// ******************************

module mchan_fifo
#(
   parameter type         T     = logic,
   parameter int unsigned DEPTH = 2
)
(
   input  logic clk_i,
   input  logic rst_ni,
   input  logic push_i,
   input  T     data_i,
   output logic full_o,
   input  logic pop_i,
   output T     data_o,
   output logic valid_o
);

   localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int unsigned CNT_W = $clog2(DEPTH + 1);

   T                 mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] cnt_q;
   logic             do_push;
   logic             do_pop;

   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && valid_o;

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (do_pop)
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         case ({do_push, do_pop})
            2'b10:   cnt_q <= cnt_q + 1'b1;
            2'b01:   cnt_q <= cnt_q - 1'b1;
            default: cnt_q <= cnt_q;  // Idle or push with pop
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (do_push)
         mem[wr_ptr_q] <= data_i;
   end

   assign data_o  = mem[rd_ptr_q];  // Head of queue
   assign valid_o = (cnt_q != '0);
   assign full_o  = (cnt_q == CNT_W'(DEPTH));

   // Producer must respect full, consumer must respect valid
   assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o);
   assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> valid_o);

endmodule

//--- mchan_pkg.sv
// ******************************
// DMA control front end types
// Control port structs and queue payloads
// ******************************

`include "mchan_cfg.svh"

package mchan_pkg;

   typedef logic [$clog2(`MCHAN_NB_TRANSFERS)-1:0] sid_t;
   typedef logic [`MCHAN_NB_TRANSFERS-1:0]         trans_mask_t;  // One bit per ID
   typedef logic [`MCHAN_TCDM_ADD_WIDTH-1:0]       tcdm_add_t;
   typedef logic [`MCHAN_EXT_ADD_WIDTH-1:0]        ext_add_t;
   typedef logic [`MCHAN_PE_ID_WIDTH-1:0]          pe_id_t;

   // ******************************
   // Control target port
   // ******************************
   typedef struct packed {
      logic        typ;   // 1 = read
      logic [3:0]  be;
      logic [31:0] add;
      logic [31:0] data;
      pe_id_t      id;    // Issuing PE
   } ctrl_req_t;

   typedef struct packed {
      logic        r_valid;
      logic [31:0] r_data;
      pe_id_t      r_id;
   } ctrl_rsp_t;

   // ******************************
   // Command queue entry
   // ******************************
   typedef struct packed {
      logic [`MCHAN_LEN_WIDTH-1:0] len;  // Bytes minus one
      logic                        opc;
      logic                        inc;
      logic                        ele;  // Event lines
      logic                        ile;  // Interrupt lines
      logic                        ble;  // Broadcast lines
      sid_t                        sid;
   } cmd_t;

endpackage

//--- mchan_cfg.svh
// ******************************
// DMA control front end configuration
// Transfer IDs, queue depth, field widths, register map
// ******************************

`ifndef MCHAN_CFG_SVH
`define MCHAN_CFG_SVH

// Transfer IDs and queue sizing
`define MCHAN_NB_TRANSFERS 4
`define MCHAN_QUEUE_DEPTH 2

// Command and address field widths
`define MCHAN_LEN_WIDTH 19
`define MCHAN_TCDM_ADD_WIDTH 12
`define MCHAN_EXT_ADD_WIDTH 29
`define MCHAN_PE_ID_WIDTH 1

// Register offsets on the control port, address bits 3:0
`define MCHAN_CMD_ADDR 4'h0
`define MCHAN_STATUS_ADDR 4'h4

// Allocated bits sit above the done bits in the status word
`define MCHAN_ALLOC_SHIFT 16

`endif
